//--- Makefile
.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove build output and the log"

test:
	verilator --binary --timing --assert -f list.f --top-module tb_top -o sim_tb
	./obj_dir/sim_tb | tee sim.log
	grep -q '^>>> PASS$$' sim.log

clean:
	rm -rf obj_dir sim.log

//--- list.f
+incdir+logic
logic/tilemap_pkg.sv
logic/cpu_port.sv
logic/slot_sequencer.sv
logic/bg_layer.sv
logic/rom_fetcher.sv
logic/priority_mixer.sv
logic/tilemap_top.sv
testbench/tb_clock.sv
testbench/tb_top.sv

//--- logic/bg_layer.sv
/*
 * Background layer
 * Scrolled fetch and draw X counters, line counter for Y and a
 * four-tile line buffer tapped by the draw counter
 */
`timescale 1ns/1ps
`default_nettype none

module bg_layer
    import tilemap_pkg::*;
#(
    parameter int READAHEAD = 32
) (
    input  logic        clk,
    input  logic        reset,
    input  logic        ce,
    input  logic        line_strobe,
    input  logic        frame_strobe,
    input  logic [8:0]  x_scroll,
    input  logic [8:0]  y_scroll,
    input  logic        load,
    input  logic [1:0]  load_index,
    input  logic [63:0] load_data,
    input  tile_attr_t  load_attr,
    output logic [8:0]  fetch_x,
    output logic [8:0]  y,
    output logic [11:0] dot
);

    logic [8:0]  draw_x;
    logic [8:0]  line_cnt;
    logic [7:0]  lead_cnt;
    logic [7:0]  color_buf [4];
    logic [63:0] pixel_buf [4];

    assign y = line_cnt + y_scroll;

    always_ff @(posedge clk) begin
        if (reset) begin
            fetch_x <= '0;
            draw_x <= '0;
            line_cnt <= '0;
            lead_cnt <= '0;
        end else if (ce) begin
            fetch_x <= fetch_x + 9'd1;
            if (lead_cnt == 8'(READAHEAD)) begin
                draw_x <= draw_x + 9'd1;
            end else begin
                lead_cnt <= lead_cnt + 8'd1;    // Draw holds until fetch is ahead
            end

            if (line_strobe) begin
                fetch_x <= x_scroll;
                draw_x <= x_scroll;
                lead_cnt <= '0;
                line_cnt <= line_cnt + 9'd1;
            end
            if (frame_strobe) begin
                line_cnt <= '1;     // First line strobe brings it to 0
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            color_buf[load_index] <= load_attr.color;
            if (load_attr.xflip) begin
                for (int i = 0; i < 16; i++) begin
                    pixel_buf[load_index][4 * (15 - i) +: 4] <= load_data[4 * i +: 4];
                end
            end else begin
                pixel_buf[load_index] <= load_data;
            end
        end
    end

    assign dot = {color_buf[draw_x[5:4]], pixel_buf[draw_x[5:4]][{draw_x[3:0], 2'b00} +: 4]};

endmodule

`default_nettype wire

//--- logic/cpu_port.sv
/*
 * CPU port
 * Decodes 68000-style accesses into the control register file or
 * pending video RAM accesses, and answers with DTACK
 */
`timescale 1ns/1ps
`default_nettype none
`include "tilemap_consts.svh"

module cpu_port
    import tilemap_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        ce,
    input  cpu_addr_t   va,
    input  logic [15:0] vd_in,
    input  logic        uds_n,
    input  logic        lds_n,
    input  logic        cs_n,
    input  logic        rw,
    input  logic        cpu_done,
    input  logic [15:0] ram_rdata,
    output logic [15:0] vd_out,
    output logic        dtack_n,
    output logic        cpu_grant_req,
    output logic [8:0]  x_scroll [`SCP_NUM_LAYERS],
    output logic [8:0]  y_scroll [`SCP_NUM_LAYERS],
    output logic [2:0]  layer_prio
);

    localparam int NUM_REGS = 32;

    logic [15:0] ctrl [NUM_REGS];
    logic        prev_cs_n;
    logic        cs_fall;
    logic        pending;

    assign cs_fall = prev_cs_n & ~cs_n;
    assign cpu_grant_req = pending;
    assign layer_prio = ctrl[`SCP_REG_LAYER_CTRL][4:2];

    always_comb begin
        for (int i = 0; i < `SCP_NUM_LAYERS; i++) begin
            x_scroll[i] = ctrl[`SCP_REG_XSCROLL + i][8:0];
            y_scroll[i] = ctrl[`SCP_REG_YSCROLL + i][8:0];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                ctrl[i] <= '0;
            end
            prev_cs_n <= 1'b1;
            dtack_n <= 1'b1;
            pending <= 1'b0;
        end else if (ce) begin
            prev_cs_n <= cs_n;
            if (cs_fall) begin
                if (va.ctrl.sel) begin
                    if (!rw) begin
                        if (!uds_n) ctrl[va.ctrl.index][15:8] <= vd_in[15:8];
                        if (!lds_n) ctrl[va.ctrl.index][7:0] <= vd_in[7:0];
                    end
                    dtack_n <= 1'b0;
                end else begin
                    pending <= 1'b1;    // Wait for a CPU slot
                end
            end else if (cs_n) begin
                dtack_n <= 1'b1;
            end

            if (cpu_done) begin
                pending <= 1'b0;
                dtack_n <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ce) begin
            if (cs_fall && va.ctrl.sel && rw) begin
                vd_out <= ctrl[va.ctrl.index];
            end else if (cpu_done && rw) begin
                vd_out <= ram_rdata;
            end
        end
    end

    // Sequencer only completes accesses that were asked for
    assert property (@(posedge clk) disable iff (reset) cpu_done |-> pending)
        else $error("cpu_done without a pending RAM access");

endmodule

`default_nettype wire

//--- logic/priority_mixer.sv
/*
 * Priority mixer
 * Orders the layers by the priority field and registers the
 * front-most opaque pixel with its layer number
 */
`timescale 1ns/1ps
`default_nettype none
`include "tilemap_consts.svh"

module priority_mixer (
    input  logic        clk,
    input  logic        ce,
    input  logic [2:0]  layer_prio,
    input  logic [11:0] dot [`SCP_NUM_LAYERS],
    output logic [14:0] sd
);

    logic [14:0] prio_dot [`SCP_NUM_LAYERS];
    logic [1:0]  pos;

    always_comb begin
        prio_dot = '{default: '0};
        for (int n = 0; n < `SCP_NUM_LAYERS; n++) begin
            pos = (layer_prio[1:0] + 2'(n)) ^ ~{2{layer_prio[2]}};
            prio_dot[pos] = {3'(n + 1), dot[n]};
        end
    end

    // Back position is the fallback, front one wins
    always_ff @(posedge clk) begin
        if (ce) begin
            sd <= prio_dot[`SCP_NUM_LAYERS - 1];
            for (int p = `SCP_NUM_LAYERS - 2; p >= 0; p--) begin
                if (|prio_dot[p][3:0]) sd <= prio_dot[p];
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/rom_fetcher.sv
/*
 * Tile ROM fetcher
 * Serves the layers' toggle requests one at a time over the ROM
 * toggle handshake. Tile code zero is blank and skips the ROM
 */
`timescale 1ns/1ps
`default_nettype none
`include "tilemap_consts.svh"

module rom_fetcher
    import tilemap_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        tile_req [`SCP_NUM_LAYERS],
    input  tile_attr_t  attr [`SCP_NUM_LAYERS],
    input  logic [8:0]  layer_y [`SCP_NUM_LAYERS],
    input  logic [63:0] rom_data,
    input  logic        rom_ack,
    output logic [22:0] rom_address,
    output logic        rom_req,
    output logic        load [`SCP_NUM_LAYERS],
    output logic [63:0] load_data
);

    logic tile_ack [`SCP_NUM_LAYERS];
    logic req_active;
    logic [$clog2(`SCP_NUM_LAYERS)-1:0] req_index;

    always_ff @(posedge clk) begin : fetch
        logic found;

        found = 1'b0;
        if (reset) begin
            rom_req <= 1'b0;
            req_active <= 1'b0;
            for (int i = 0; i < `SCP_NUM_LAYERS; i++) begin
                tile_ack[i] <= 1'b0;
                load[i] <= 1'b0;
            end
        end else begin
            for (int i = 0; i < `SCP_NUM_LAYERS; i++) begin
                load[i] <= 1'b0;
            end

            if (req_active) begin
                if (rom_ack == rom_req) begin
                    load[req_index] <= 1'b1;
                    load_data <= rom_data;
                    tile_ack[req_index] <= tile_req[req_index];  // Merges a repeat
                    req_active <= 1'b0;
                end
            end else begin
                for (int i = 0; i < `SCP_NUM_LAYERS; i++) begin
                    if (!found && tile_req[i] != tile_ack[i]) begin
                        found = 1'b1;
                        if (attr[i].code != 16'd0) begin
                            rom_address <= {attr[i].code,
                                            layer_y[i][3:0] ^ {4{attr[i].yflip}}, 3'b000};
                            rom_req <= ~rom_req;
                            req_active <= 1'b1;
                            req_index <= ($clog2(`SCP_NUM_LAYERS))'(i);
                        end else begin
                            tile_ack[i] <= tile_req[i];
                            load[i] <= 1'b1;
                            load_data <= '0;    // Blank tile
                        end
                    end
                end
            end
        end
    end

    // One ROM fetch in flight
    assert property (@(posedge clk) disable iff (reset) req_active |=> $stable(rom_req))
        else $error("ROM request started while one is active");

endmodule

`default_nettype wire

//--- logic/slot_sequencer.sv
/*
 * Slot sequencer
 * Runs the per-line video RAM schedule: idle start slots, then a
 * repeating cycle of two CPU slots and two attribute reads per layer.
 * Captures tile attributes, requests tile fetches and makes the
 * line and frame strobes
 */
`timescale 1ns/1ps
`default_nettype none
`include "tilemap_consts.svh"

module slot_sequencer
    import tilemap_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        ce,
    input  logic        hld_n,
    input  logic        vld_n,
    input  logic        cpu_grant_req,
    input  logic [14:0] cpu_addr,
    input  logic [15:0] cpu_wdata,
    input  logic        cpu_rw,
    input  logic        cpu_uds_n,
    input  logic        cpu_lds_n,
    input  logic [15:0] ram_rdata,
    input  logic [8:0]  layer_fetch_x [`SCP_NUM_LAYERS],
    input  logic [8:0]  layer_y [`SCP_NUM_LAYERS],
    output logic [14:0] ram_addr,
    output logic [15:0] ram_wdata,
    output logic        ram_we_hi_n,
    output logic        ram_we_lo_n,
    output logic        cpu_done,
    output tile_attr_t  attr [`SCP_NUM_LAYERS],
    output logic        tile_req [`SCP_NUM_LAYERS],
    output logic [1:0]  load_index [`SCP_NUM_LAYERS],
    output logic        line_strobe,
    output logic        frame_strobe
);

    slot_t       slot;
    slot_t       next_slot;
    slot_t       slot_d;
    logic        prev_hld_n;
    logic        prev_vld_n;
    logic        hld_fall;
    logic        cpu_slot;
    logic        cpu_active;
    logic        attr_slot;
    logic        attr_lo;
    logic [1:0]  slot_layer;
    logic [8:0]  x_lat;
    logic [8:0]  x_sel;
    logic [15:0] attr_byte_addr;

    assign hld_fall = prev_hld_n & ~hld_n;
    assign cpu_slot = (slot == SLOT_CPU_A) || (slot == SLOT_CPU_B);
    assign cpu_done = cpu_slot & cpu_active;

    always_comb begin
        if (slot == slot_t'(`SCP_START_SLOTS + `SCP_LINE_SLOTS - 1)) begin
            next_slot = slot_t'(`SCP_START_SLOTS);   // Back to CPU_A
        end else begin
            next_slot = slot_t'(slot + 5'd1);
        end
        slot_d = hld_fall ? SLOT_START0 : next_slot;
    end

    always_comb begin
        attr_slot = 1'b1;
        slot_layer = 2'd0;
        unique case (slot)
            SLOT_BG0_ATTR_HI, SLOT_BG0_ATTR_LO: slot_layer = 2'd0;
            SLOT_BG1_ATTR_HI, SLOT_BG1_ATTR_LO: slot_layer = 2'd1;
            SLOT_BG2_ATTR_HI, SLOT_BG2_ATTR_LO: slot_layer = 2'd2;
            SLOT_BG3_ATTR_HI, SLOT_BG3_ATTR_LO: slot_layer = 2'd3;
            default: attr_slot = 1'b0;
        endcase
    end

    assign attr_lo = slot inside {SLOT_BG0_ATTR_LO, SLOT_BG1_ATTR_LO,
                                  SLOT_BG2_ATTR_LO, SLOT_BG3_ATTR_LO};

    // Low word reuses the X sampled for the high word
    assign x_sel = attr_lo ? x_lat : layer_fetch_x[slot_layer];
    assign attr_byte_addr = 16'(slot_layer) * `SCP_BG_RAM_STEP
                          + {4'd0, layer_y[slot_layer][8:4], x_sel[8:4], attr_lo, 1'b0};

    assign ram_addr = cpu_slot ? cpu_addr : attr_byte_addr[15:1];
    assign ram_wdata = cpu_wdata;
    assign ram_we_hi_n = ~(cpu_done & ~cpu_rw & ~cpu_uds_n);
    assign ram_we_lo_n = ~(cpu_done & ~cpu_rw & ~cpu_lds_n);

    always_ff @(posedge clk) begin
        if (reset) begin
            slot <= SLOT_START0;
            prev_hld_n <= 1'b1;
            prev_vld_n <= 1'b1;
            cpu_active <= 1'b0;
            line_strobe <= 1'b0;
            frame_strobe <= 1'b0;
            for (int i = 0; i < `SCP_NUM_LAYERS; i++) begin
                tile_req[i] <= 1'b0;
            end
        end else if (ce) begin
            prev_hld_n <= hld_n;
            prev_vld_n <= vld_n;
            slot <= slot_d;
            cpu_active <= cpu_grant_req && (slot_d == SLOT_CPU_A || slot_d == SLOT_CPU_B);
            line_strobe <= !hld_fall && (slot == slot_t'(`SCP_START_SLOTS - 1));
            frame_strobe <= prev_vld_n & ~vld_n;
            if (attr_slot && attr_lo) begin
                tile_req[slot_layer] <= ~tile_req[slot_layer];   // Toggle request
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ce && attr_slot) begin
            if (attr_lo) begin
                attr[slot_layer][15:0] <= ram_rdata;
                load_index[slot_layer] <= x_lat[5:4];
            end else begin
                attr[slot_layer][31:16] <= ram_rdata;
                x_lat <= layer_fetch_x[slot_layer];
            end
        end
    end

    assert property (@(posedge clk) disable iff (reset)
        !(ram_we_hi_n && ram_we_lo_n) |-> (slot == SLOT_CPU_A || slot == SLOT_CPU_B))
        else $error("RAM write strobe outside a CPU slot");

endmodule

`default_nettype wire

//--- logic/tilemap_consts.svh
/*
 * Tilemap core constants
 * Slot schedule lengths, attribute map layout in video RAM,
 * control register map and per-layer fetch read-ahead
 */
`ifndef TILEMAP_CONSTS_SVH
`define TILEMAP_CONSTS_SVH

`define SCP_NUM_LAYERS      4

// Slot schedule
`define SCP_START_SLOTS     4
`define SCP_LINE_SLOTS      10

// Byte distance between layer attribute maps
`define SCP_BG_RAM_STEP     16'h1000

// Control register bases
`define SCP_REG_XSCROLL     0
`define SCP_REG_YSCROLL     4
`define SCP_REG_LAYER_CTRL  15

// Fetch lead over draw, in pixels
`define SCP_READAHEAD_BASE  32
`define SCP_READAHEAD_STEP  4

`endif

//--- logic/tilemap_pkg.sv
/*
 * Tilemap core types
 * Slot states, tile attribute layout and CPU address decode
 */
`default_nettype none

package tilemap_pkg;

    typedef enum logic [4:0] {
        SLOT_START0 = 5'd0,
        SLOT_START1,
        SLOT_START2,
        SLOT_START3,
        SLOT_CPU_A,
        SLOT_BG0_ATTR_HI,
        SLOT_BG0_ATTR_LO,
        SLOT_BG1_ATTR_HI,
        SLOT_BG1_ATTR_LO,
        SLOT_CPU_B,
        SLOT_BG2_ATTR_HI,
        SLOT_BG2_ATTR_LO,
        SLOT_BG3_ATTR_HI,
        SLOT_BG3_ATTR_LO
    } slot_t;

    // High RAM word first, then the low one
    typedef struct packed {
        logic        yflip;
        logic        xflip;
        logic [5:0]  rsvd;
        logic [7:0]  color;
        logic [15:0] code;
    } tile_attr_t;

    typedef union packed {
        struct packed {
            logic        sel;       // Set for control registers
            logic [10:0] pad;
            logic [4:0]  index;
            logic        byte_lsb;
        } ctrl;
        struct packed {
            logic [1:0]  upper;
            logic [14:0] word;
            logic        byte_lsb;
        } ram;
    } cpu_addr_t;

endpackage

`default_nettype wire

//--- logic/tilemap_top.sv
/*
 * Tilemap core top level
 * CPU port and slot sequencer on the input side, four background
 * layers fed by the ROM fetcher, priority mixer on the output
 */
`timescale 1ns/1ps
`default_nettype none
`include "tilemap_consts.svh"

module tilemap_top
    import tilemap_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        ce,
    input  cpu_addr_t   va,
    input  logic [15:0] vd_in,
    input  logic        uds_n,
    input  logic        lds_n,
    input  logic        cs_n,
    input  logic        rw,
    input  logic [15:0] ram_rdata,
    input  logic [63:0] rom_data,
    input  logic        rom_ack,
    input  logic        hld_n,
    input  logic        vld_n,
    output logic [15:0] vd_out,
    output logic        dtack_n,
    output logic [14:0] ram_addr,
    output logic [15:0] ram_wdata,
    output logic        ram_we_hi_n,
    output logic        ram_we_lo_n,
    output logic [22:0] rom_address,
    output logic        rom_req,
    output logic [14:0] sd
);

    logic        cpu_done;
    logic        cpu_grant_req;
    logic [8:0]  x_scroll [`SCP_NUM_LAYERS];
    logic [8:0]  y_scroll [`SCP_NUM_LAYERS];
    logic [2:0]  layer_prio;
    logic [8:0]  fetch_x [`SCP_NUM_LAYERS];
    logic [8:0]  layer_y [`SCP_NUM_LAYERS];
    tile_attr_t  attr [`SCP_NUM_LAYERS];
    logic        tile_req [`SCP_NUM_LAYERS];
    logic [1:0]  load_index [`SCP_NUM_LAYERS];
    logic        load [`SCP_NUM_LAYERS];
    logic [63:0] load_data;
    logic [11:0] dot [`SCP_NUM_LAYERS];
    logic        line_strobe;
    logic        frame_strobe;

    cpu_port u_cpu (
        .clk, .reset, .ce, .va, .vd_in, .uds_n, .lds_n, .cs_n, .rw,
        .cpu_done, .ram_rdata, .vd_out, .dtack_n, .cpu_grant_req,
        .x_scroll, .y_scroll, .layer_prio
    );

    slot_sequencer u_seq (
        .clk, .reset, .ce, .hld_n, .vld_n, .cpu_grant_req,
        .cpu_addr(va.ram.word), .cpu_wdata(vd_in), .cpu_rw(rw),
        .cpu_uds_n(uds_n), .cpu_lds_n(lds_n), .ram_rdata,
        .layer_fetch_x(fetch_x), .layer_y, .ram_addr, .ram_wdata,
        .ram_we_hi_n, .ram_we_lo_n, .cpu_done, .attr, .tile_req,
        .load_index, .line_strobe, .frame_strobe
    );

    for (genvar i = 0; i < `SCP_NUM_LAYERS; i++) begin : g_layer
        bg_layer #(.READAHEAD(`SCP_READAHEAD_BASE + i * `SCP_READAHEAD_STEP)) u_layer (
            .clk, .reset, .ce, .line_strobe, .frame_strobe,
            .x_scroll(x_scroll[i]), .y_scroll(y_scroll[i]),
            .load(load[i]), .load_index(load_index[i]), .load_data,
            .load_attr(attr[i]), .fetch_x(fetch_x[i]), .y(layer_y[i]), .dot(dot[i])
        );
    end

    rom_fetcher u_fetch (
        .clk, .reset, .tile_req, .attr, .layer_y, .rom_data, .rom_ack,
        .rom_address, .rom_req, .load, .load_data
    );

    priority_mixer u_mix (
        .clk, .ce, .layer_prio, .dot, .sd
    );

endmodule

`default_nettype wire

//--- testbench/tb_clock.sv
/*
 * Testbench clock and reset
 * 4 ns clock, reset held high for the first 5 cycles
 */
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        reset = 1'b1;
        repeat (5) @(posedge clk);
        reset <= #1 1'b0;
    end

endmodule

`default_nettype wire

//--- testbench/tb_top.sv
/*
 * Tilemap core testbench
 * Video RAM and tile ROM models around the DUT, a CPU bus driver
 * and a command reader that runs the stimulus file and checks
 * register, RAM, ROM address and pixel output values
 */
`timescale 1ns/1ps
`default_nettype none
`include "tilemap_consts.svh"

module tb_top
    import tilemap_pkg::*;
;

    localparam int LINE_CYCLES = 400;

    logic        clk;
    logic        reset;
    cpu_addr_t   va = '0;
    logic [15:0] vd_in = '0;
    logic        uds_n = 1'b1;
    logic        lds_n = 1'b1;
    logic        cs_n = 1'b1;
    logic        rw = 1'b1;
    logic [15:0] ram_rdata;
    logic [63:0] rom_data = '0;
    logic        rom_ack = 1'b0;
    logic        hld_n = 1'b1;
    logic        vld_n = 1'b1;
    logic [15:0] vd_out;
    logic        dtack_n;
    logic [14:0] ram_addr;
    logic [15:0] ram_wdata;
    logic        ram_we_hi_n;
    logic        ram_we_lo_n;
    logic [22:0] rom_address;
    logic        rom_req;
    logic [14:0] sd;

    logic [15:0] ram [32768];
    logic [63:0] pattern [logic [15:0]];
    logic [15:0] shadow_reg [32];
    logic [15:0] shadow_code [`SCP_NUM_LAYERS];
    logic        shadow_yflip [`SCP_NUM_LAYERS];

    // Backdoor map fill done by the RAM process
    logic        fill_go = 1'b0;
    logic [1:0]  fill_sel = '0;
    logic [15:0] fill_hi = '0;
    logic [15:0] fill_lo = '0;

    int          cyc = 0;
    int          cycle_limit = 1000000;
    int          rom_requests = 0;
    int          rom_wait = 0;
    logic        rom_busy = 1'b0;
    logic        req_seen = 1'b0;
    logic [8:0]  tb_line = '0;
    logic [8:0]  line_lag = '0;

    byte         op_q [$];
    logic [31:0] addr_q [$];
    logic [31:0] data_q [$];
    logic [31:0] aux_q [$];

    tb_clock clock0 (.clk, .reset);

    tilemap_top dut0 (
        .clk, .reset, .ce(1'b1), .va, .vd_in, .uds_n, .lds_n, .cs_n, .rw,
        .ram_rdata, .rom_data, .rom_ack, .hld_n, .vld_n, .vd_out, .dtack_n,
        .ram_addr, .ram_wdata, .ram_we_hi_n, .ram_we_lo_n, .rom_address,
        .rom_req, .sd
    );

    assign ram_rdata = ram[ram_addr];   // Combinational read

    task automatic fail_run(input string what);
        $display("%0t: %s", $time, what);
        $display(">>> FAIL");
        $fatal(1, "stopped on first error");
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
            $display(">>> FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    // Row is Y after scroll and flipped under Y-flip
    task automatic check_rom_address(input logic [8:0] line);
        int          found;
        logic [8:0]  y;
        logic [3:0]  row;
        logic [22:0] exp_addr;

        found = -1;
        for (int l = 0; l < `SCP_NUM_LAYERS; l++) begin
            if (found < 0 && shadow_code[l] != 16'd0 && shadow_code[l] == rom_address[22:7])
                found = l;
        end
        if (found < 0) begin
            fail_run("ROM request for a tile code that no layer holds");
        end else begin
            y = line + shadow_reg[`SCP_REG_YSCROLL + found][8:0];
            row = y[3:0] ^ {4{shadow_yflip[found]}};
            exp_addr = {shadow_code[found], row, 3'b000};
            check_value("rom_address", {41'd0, rom_address}, {41'd0, exp_addr});
        end
    endtask

    // RAM, ROM, line tracking, hld_n and run limit
    always @(posedge clk) begin
        if (reset) begin
            cyc = 0;
            tb_line = '0;
            line_lag = '0;
            req_seen = 1'b0;
            rom_busy = 1'b0;
            for (int a = 0; a < 32768; a++) begin
                ram[a] <= (a < 32'h2000) ? 16'h0000 : (16'(a) ^ 16'(a >> 5) ^ 16'h5a3c);
            end
        end else begin
            cyc = cyc + 1;
            if (cyc > cycle_limit) fail_run("run hit its cycle limit before the stimulus ended");
            hld_n <= #1 (cyc % LINE_CYCLES != 0);

            if (!ram_we_hi_n) ram[ram_addr][15:8] <= ram_wdata[15:8];
            if (!ram_we_lo_n) ram[ram_addr][7:0] <= ram_wdata[7:0];
            if (fill_go) begin
                for (int t = 0; t < 1024; t++) begin
                    ram[15'(fill_sel * (`SCP_BG_RAM_STEP / 2) + t * 2)] <= fill_hi;
                    ram[15'(fill_sel * (`SCP_BG_RAM_STEP / 2) + t * 2 + 1)] <= fill_lo;
                end
            end

            if (rom_req !== req_seen) begin
                req_seen = rom_req;
                rom_requests++;
                check_rom_address(line_lag);
                rom_busy = 1'b1;
                rom_wait = $urandom_range(4, 1) - 1;
            end
            if (rom_busy) begin
                if (rom_wait == 0) begin
                    rom_data <= #1 pattern.exists(rom_address[22:7]) ?
                                   pattern[rom_address[22:7]] : 64'd0;
                    rom_ack <= #1 req_seen;
                    rom_busy = 1'b0;
                end else begin
                    rom_wait--;
                end
            end

            // Line count as the layers see it 6 cycles after hld_n falls
            line_lag = tb_line;
            if (cyc == 5 || (cyc > LINE_CYCLES && cyc % LINE_CYCLES == 6)) tb_line++;
        end
    end

    task automatic cpu_access(input logic ctrl, input logic [14:0] addr, input logic wr,
                              input logic [15:0] data, input logic [1:0] mask,
                              output logic [15:0] rdata);
        int waited;

        waited = 0;
        @(posedge clk);
        #1;
        va = '0;
        if (ctrl) begin
            va.ctrl.sel = 1'b1;
            va.ctrl.index = addr[4:0];
        end else begin
            va.ram.word = addr;
        end
        rw = ~wr;
        vd_in = data;
        uds_n = ~mask[1];
        lds_n = ~mask[0];
        cs_n = 1'b0;
        @(posedge clk);
        while (dtack_n !== 1'b0) begin
            waited++;
            if (waited > 50) fail_run("DTACK never went low for a CPU access");
            @(posedge clk);
        end
        rdata = vd_out;
        #1;
        cs_n = 1'b1;
        rw = 1'b1;
        uds_n = 1'b1;
        lds_n = 1'b1;
        waited = 0;
        while (dtack_n !== 1'b1) begin
            waited++;
            if (waited > 50) fail_run("DTACK stayed low after chip select was released");
            @(posedge clk);
        end
    endtask

    task automatic fill_layer(input logic [1:0] layer, input logic [15:0] hi,
                              input logic [15:0] lo);
        @(posedge clk);
        #1;
        fill_sel = layer;
        fill_hi = hi;
        fill_lo = lo;
        shadow_code[layer] = lo;
        shadow_yflip[layer] = hi[15];
        fill_go = 1'b1;
        @(posedge clk);
        #1;
        fill_go = 1'b0;
    endtask

    // One full line and then time for the buffers to refill
    task automatic wait_sd(input logic [14:0] exp);
        int waited;

        waited = 0;
        repeat (LINE_CYCLES) @(posedge clk);
        while (sd !== exp && waited < 1600) begin
            waited++;
            @(posedge clk);
        end
        check_value("sd", {49'd0, sd}, {49'd0, exp});
    endtask

    task automatic run_command(input byte op, input logic [31:0] a, input logic [31:0] d,
                               input logic [31:0] x);
        logic [15:0] rd;

        case (op)
            "W": begin
                cpu_access(1'b1, a[14:0], 1'b1, d[15:0], x[1:0], rd);
                if (x[1]) shadow_reg[a[4:0]][15:8] = d[15:8];
                if (x[0]) shadow_reg[a[4:0]][7:0] = d[7:0];
            end
            "R": begin
                cpu_access(1'b1, a[14:0], 1'b0, 16'd0, 2'b11, rd);
                check_value("vd_out", {48'd0, rd}, {32'd0, x});
            end
            "M": cpu_access(1'b0, a[14:0], 1'b1, d[15:0], x[1:0], rd);
            "Q": begin
                cpu_access(1'b0, a[14:0], 1'b0, 16'd0, 2'b11, rd);
                check_value("vd_out", {48'd0, rd}, {32'd0, x});
            end
            "F": fill_layer(a[1:0], d[15:0], x[15:0]);
            "P": pattern[a[15:0]] = {4{d[15:0]}};
            "S": wait_sd(x[14:0]);
            "N": check_value("rom requests", 64'(rom_requests), {32'd0, x});
            default: fail_run("unknown command in the stimulus file");
        endcase
    endtask

    initial begin
        int          fd;
        int          n;
        string       line;
        byte         op;
        logic [31:0] a;
        logic [31:0] d;
        logic [31:0] x;

        void'($urandom(32'h6ea53e39));
        for (int i = 0; i < 32; i++) shadow_reg[i] = '0;
        for (int l = 0; l < `SCP_NUM_LAYERS; l++) begin
            shadow_code[l] = '0;
            shadow_yflip[l] = 1'b0;
        end

        fd = $fopen("testbench/tilemap_stim.txt", "r");
        if (fd == 0) fail_run("cannot open the stimulus file");
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() > 1 && line[0] != "#") begin
                n = $sscanf(line, "%c %h %h %h", op, a, d, x);
                if (n == 4) begin
                    op_q.push_back(op);
                    addr_q.push_back(a);
                    data_q.push_back(d);
                    aux_q.push_back(x);
                end
            end
        end
        $fclose(fd);
        cycle_limit = 200 * op_q.size() + 2000;

        wait (reset === 1'b0);
        repeat (4) @(posedge clk);
        for (int i = 0; i < op_q.size(); i++) begin
            run_command(op_q[i], addr_q[i], data_q[i], aux_q[i]);
        end
        $display(">>> PASS");
        $finish;
    end

endmodule

`default_nettype wire

//--- testbench/tilemap_stim.txt
# op addr data aux (hex). W/R register, M/Q RAM word, F layer fill (data=attr hi, aux=code),
# P code pattern word, S expected sd, N expected ROM request count. W/M aux is the byte mask.
W 00 1234 3
R 00 0000 1234
W 00 abcd 2
R 00 0000 ab34
W 00 ffee 1
R 00 0000 abee
W 05 0003 3
R 05 0000 0003
W 1f 5a00 2
R 1f 0000 5a00
M 2345 beef 3
Q 2345 0000 beef
M 2345 1200 1
Q 2345 0000 be00
M 7ffe 0ff0 3
Q 7ffe 0000 0ff0
F 0 8011 0000
F 1 4022 0000
F 2 0033 0000
F 3 c044 0000
S 0 0000 1110
N 0 0000 0000
P 0101 1111 0
P 0202 2222 0
P 0303 3333 0
P 0404 4444 0
F 0 8011 0101
F 1 4022 0202
F 2 0033 0303
F 3 c044 0404
S 0 0000 4444
W 0f 0010 3
S 0 0000 1111
W 0f 0018 3
S 0 0000 3333
W 0f 0008 3
S 0 0000 2222
